//--- trellisPkg.sv
// Structure constants of the 20-state trellis only; the stride rule below is not generic
`default_nettype none

package trellisPkg;

   // ----------------------------------------
   // Trellis shape
   // ----------------------------------------
   localparam int numStates     = 20;
   localparam int trellisStride = 7;    // Select 0 predecessor offset
   localparam int tbDepth       = 8;    // Stages per traceback block
   localparam int histDepth     = tbDepth + 2;  // Room for two symbols arriving mid-walk
   localparam int popGap        = 4;    // Clocks between output bits

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef logic [4:0] stateIdx;                // Trellis state number
   typedef logic [numStates-1:0] decisionVec;   // One select bit per state
   typedef logic [3:0] stageT;                  // Stage, history and stack positions

   // Predecessor of a state for a given select bit
   // Select 0 is state plus 7, select 1 is state plus 13, both modulo 20
   function automatic stateIdx predecessor(stateIdx state, logic sel);
      logic [5:0] sum;
      if (sel) begin
         sum = {1'b0, state} + 6'(numStates - trellisStride);
      end else begin
         sum = {1'b0, state} + 6'(trellisStride);
      end
      if (sum >= 6'(numStates)) begin
         return stateIdx'(sum - 6'(numStates));
      end
      return stateIdx'(sum);
   endfunction

endpackage

`default_nettype wire

//--- demodPkg.sv
// Signal-side widths and points; the constellation table assumes trellisPkg is compiled first
`default_nettype none

package demodPkg;

   // ----------------------------------------
   // Widths and types
   // ----------------------------------------
   localparam int sampleW = 8;
   localparam int metricW = 12;
   localparam int branchW = 9;    // Holds |dI| + |dQ| up to 456

   typedef logic signed [sampleW-1:0] sample;
   typedef logic [metricW-1:0]        metric;
   typedef logic [branchW-1:0]        branchMetricT;

   // Path metrics stop here instead of wrapping
   localparam metric metricMax = metric'((1 << metricW) - 1);

   // ----------------------------------------
   // Expected point of each state
   // ----------------------------------------
   // Amplitude 100, phase 18 degrees per state, rounded
   localparam sample expectedI [trellisPkg::numStates] = '{
      8'sd100,  8'sd95,   8'sd81,   8'sd59,
      8'sd31,   8'sd0,   -8'sd31,  -8'sd59,
     -8'sd81,  -8'sd95,  -8'sd100, -8'sd95,
     -8'sd81,  -8'sd59,  -8'sd31,   8'sd0,
      8'sd31,   8'sd59,   8'sd81,   8'sd95
   };

   localparam sample expectedQ [trellisPkg::numStates] = '{
      8'sd0,    8'sd31,   8'sd59,   8'sd81,
      8'sd95,   8'sd100,  8'sd95,   8'sd81,
      8'sd59,   8'sd31,   8'sd0,   -8'sd31,
     -8'sd59,  -8'sd81,  -8'sd95,  -8'sd100,
     -8'sd95,  -8'sd81,  -8'sd59,  -8'sd31
   };

endpackage

`default_nettype wire

//--- bitLifo.sv
// Pushes past full and pops when empty are dropped; a push and pop together replace the top
`default_nettype none

module bitLifo (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic enIn,
   input  wire logic din,
   input  wire logic enOut,
   output logic      dout
);

   logic              stack [trellisPkg::histDepth];
   trellisPkg::stageT ptr;      // Number of stored bits
   trellisPkg::stageT topIdx;
   logic              canPush;
   logic              canPop;

   assign topIdx  = ptr - 1'b1;
   assign canPush = (ptr != trellisPkg::stageT'(trellisPkg::histDepth));
   assign canPop  = (ptr != '0);

   // Storage
   always_ff @(posedge clk) begin
      if (enIn && enOut && canPop) begin
         stack[topIdx] <= din;   // Swap in place
      end else if (enIn && canPush) begin
         stack[ptr] <= din;
      end
   end

   // Pointer and output bit
   always_ff @(posedge clk) begin
      if (reset) begin
         ptr  <= '0;
         dout <= 1'b0;
      end else if (enOut && canPop) begin
         dout <= stack[topIdx];   // Holds until the next pop
         if (!enIn) begin
            ptr <= topIdx;
         end
      end else if (enIn && canPush) begin
         ptr <= ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- branchMetric.sv
// Samples are taken only in the symEn cycle; branch metrics are valid while bmValid is high
`default_nettype none

module branchMetric (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   symEn,
   input  wire demodPkg::sample        sampleI,
   input  wire demodPkg::sample        sampleQ,
   output logic                        bmValid,
   output demodPkg::branchMetricT      branchMetrics [trellisPkg::numStates]
);

   demodPkg::sample sampleIReg;
   demodPkg::sample sampleQReg;

   // Sample capture
   always_ff @(posedge clk) begin
      if (symEn) begin
         sampleIReg <= sampleI;
         sampleQReg <= sampleQ;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bmValid <= 1'b0;
      end else begin
         bmValid <= symEn;    // Metrics follow the captured sample by one clock
      end
   end

   // ----------------------------------------
   // Manhattan distance to every state point
   // ----------------------------------------
   for (genvar s = 0; s < trellisPkg::numStates; s++) begin : gState
      logic signed [demodPkg::sampleW+1:0] diffI;
      logic signed [demodPkg::sampleW+1:0] diffQ;
      logic [demodPkg::sampleW+1:0]        absI;
      logic [demodPkg::sampleW+1:0]        absQ;

      assign diffI = sampleIReg - demodPkg::expectedI[s];
      assign diffQ = sampleQReg - demodPkg::expectedQ[s];

      assign absI = diffI[demodPkg::sampleW+1] ? -diffI : diffI;
      assign absQ = diffQ[demodPkg::sampleW+1] ? -diffQ : diffQ;

      // Sum stays under 512
      assign branchMetrics[s] = demodPkg::branchMetricT'(absI + absQ);
   end

endmodule

`default_nettype wire

//--- acsUnit.sv
// Path metrics update only on bmValid; decisions and bestState hold until the next selValid
`default_nettype none

module acsUnit (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   bmValid,
   input  wire demodPkg::branchMetricT branchMetrics [trellisPkg::numStates],
   output logic                        selValid,
   output trellisPkg::decisionVec      decisions,
   output trellisPkg::stateIdx         bestState
);

   demodPkg::metric        pathMetric [trellisPkg::numStates];
   wire demodPkg::metric   nextMetric [trellisPkg::numStates];
   wire trellisPkg::decisionVec nextSel;
   demodPkg::metric        oldMin;
   demodPkg::metric        newMin;
   trellisPkg::stateIdx    newBest;

   // Smallest old metric is taken off every survivor
   always_comb begin
      oldMin = pathMetric[0];
      for (int s = 1; s < trellisPkg::numStates; s++) begin
         if (pathMetric[s] < oldMin) begin
            oldMin = pathMetric[s];
         end
      end
   end

   // ----------------------------------------
   // Add, compare, select per state
   // ----------------------------------------
   for (genvar s = 0; s < trellisPkg::numStates; s++) begin : gAcs
      demodPkg::metric              m0;
      demodPkg::metric              m1;
      logic [demodPkg::metricW:0]   sum;

      assign m0 = pathMetric[trellisPkg::predecessor(trellisPkg::stateIdx'(s), 1'b0)];
      assign m1 = pathMetric[trellisPkg::predecessor(trellisPkg::stateIdx'(s), 1'b1)];

      assign nextSel[s] = (m1 < m0);   // Tie keeps select 0

      // Survivor is never below oldMin so the subtraction cannot wrap
      assign sum = (nextSel[s] ? m1 : m0) - oldMin + branchMetrics[s];

      assign nextMetric[s] = (sum > demodPkg::metricMax) ? demodPkg::metricMax
                                                        : sum[demodPkg::metricW-1:0];
   end

   // Best new state with the lowest index winning a tie
   always_comb begin
      newMin  = nextMetric[0];
      newBest = '0;
      for (int s = 1; s < trellisPkg::numStates; s++) begin
         if (nextMetric[s] < newMin) begin
            newMin  = nextMetric[s];
            newBest = trellisPkg::stateIdx'(s);
         end
      end
   end

   // ----------------------------------------
   // Registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         selValid <= 1'b0;
         for (int s = 0; s < trellisPkg::numStates; s++) begin
            pathMetric[s] <= '0;
         end
      end else begin
         selValid <= bmValid;
         if (bmValid) begin
            for (int s = 0; s < trellisPkg::numStates; s++) begin
               pathMetric[s] <= nextMetric[s];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bmValid) begin
         decisions <= nextSel;
         bestState <= newBest;
      end
   end

endmodule

`default_nettype wire

//--- traceBackTable.sv
// Needs symbols at least 5 clocks apart so one block's pops end before the next walk starts
`default_nettype none

module traceBackTable (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   selValid,
   input  wire trellisPkg::decisionVec decisions,
   input  wire trellisPkg::stateIdx    bestState,
   output logic                        decision,
   output logic                        decisionEn
);

   logic [trellisPkg::histDepth-1:0] hist [trellisPkg::numStates];  // Bit 0 is newest

   trellisPkg::stageT   symCnt;     // Symbols within the current block
   trellisPkg::stageT   stageCnt;   // tbDepth means idle
   trellisPkg::stageT   shiftCnt;   // Symbols shifted in since the walk began
   trellisPkg::stageT   histIdx;
   trellisPkg::stateIdx tbState;
   trellisPkg::stageT   popsLeft;
   trellisPkg::stageT   paceCnt;
   logic                popStrobe;
   logic                newTrace;
   logic                walking;
   logic                lastStep;
   logic                tbBit;

   // ----------------------------------------
   // Select history
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < trellisPkg::numStates; s++) begin
            hist[s] <= '0;
         end
      end else if (selValid) begin
         for (int s = 0; s < trellisPkg::numStates; s++) begin
            hist[s] <= {hist[s][trellisPkg::histDepth-2:0], decisions[s]};
         end
      end
   end

   // ----------------------------------------
   // Traceback walk
   // ----------------------------------------
   assign newTrace = selValid && (symCnt == trellisPkg::stageT'(trellisPkg::tbDepth - 1));
   assign walking  = (stageCnt != trellisPkg::stageT'(trellisPkg::tbDepth));
   assign lastStep = (stageCnt == trellisPkg::stageT'(trellisPkg::tbDepth - 1));

   // Stage 0 sits one symbol back, later symbols push the history further
   assign histIdx = stageCnt + shiftCnt + trellisPkg::stageT'(1);
   assign tbBit   = hist[tbState][histIdx];

   always_ff @(posedge clk) begin
      if (reset) begin
         symCnt   <= '0;
         stageCnt <= trellisPkg::stageT'(trellisPkg::tbDepth);
         shiftCnt <= '0;
         tbState  <= '0;
      end else begin
         if (newTrace) begin
            symCnt <= '0;
         end else if (selValid) begin
            symCnt <= symCnt + 1'b1;
         end

         if (newTrace) begin
            // Current selects are not in the history yet
            tbState  <= trellisPkg::predecessor(bestState, decisions[bestState]);
            stageCnt <= '0;
            shiftCnt <= '0;
         end else if (walking) begin
            tbState  <= trellisPkg::predecessor(tbState, tbBit);
            stageCnt <= stageCnt + 1'b1;
            if (selValid) begin
               shiftCnt <= shiftCnt + 1'b1;
            end
         end
      end
   end

   // ----------------------------------------
   // Output pacing
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         popsLeft   <= '0;
         paceCnt    <= '0;
         popStrobe  <= 1'b0;
         decisionEn <= 1'b0;
      end else begin
         decisionEn <= popStrobe;   // LIFO output is ready one clock after the pop
         if (walking && lastStep) begin
            popsLeft  <= trellisPkg::stageT'(trellisPkg::tbDepth);
            paceCnt   <= '0;
            popStrobe <= 1'b0;
         end else if (popsLeft != '0 && paceCnt == '0) begin
            popStrobe <= 1'b1;
            popsLeft  <= popsLeft - 1'b1;
            paceCnt   <= trellisPkg::stageT'(trellisPkg::popGap - 1);
         end else begin
            popStrobe <= 1'b0;
            if (paceCnt != '0) begin
               paceCnt <= paceCnt - 1'b1;
            end
         end
      end
   end

   // Newest bit goes in first so the oldest comes out first
   bitLifo u_bitLifo (
      .clk   (clk),
      .reset (reset),
      .enIn  (walking),
      .din   (tbBit),
      .enOut (popStrobe),
      .dout  (decision)
   );

endmodule

`default_nettype wire

//--- trellisDecoder.sv
// One sample per symEn with no back-pressure; decision is meaningful only while decisionEn is high
`default_nettype none

module trellisDecoder (
   input  wire logic            clk,
   input  wire logic            reset,
   input  wire logic            symEn,
   input  wire demodPkg::sample sampleI,
   input  wire demodPkg::sample sampleQ,
   output logic                 decision,
   output logic                 decisionEn
);

   logic                   bmValid;
   demodPkg::branchMetricT branchMetrics [trellisPkg::numStates];
   logic                   selValid;
   trellisPkg::decisionVec decisions;
   trellisPkg::stateIdx    bestState;

   branchMetric u_branchMetric (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .sampleI       (sampleI),
      .sampleQ       (sampleQ),
      .bmValid       (bmValid),
      .branchMetrics (branchMetrics)
   );

   acsUnit u_acsUnit (
      .clk           (clk),
      .reset         (reset),
      .bmValid       (bmValid),
      .branchMetrics (branchMetrics),
      .selValid      (selValid),
      .decisions     (decisions),
      .bestState     (bestState)
   );

   traceBackTable u_traceBackTable (
      .clk        (clk),
      .reset      (reset),
      .selValid   (selValid),
      .decisions  (decisions),
      .bestState  (bestState),
      .decision   (decision),
      .decisionEn (decisionEn)
   );

endmodule

`default_nettype wire

//--- trellisDecoderTb.sv
// Symbols every 6 clocks from a 20-state encoder model; every wait has a clock-count timeout
`default_nettype none

module trellisDecoderTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int skipOut  = 16;    // Start-up outputs left out of the alignment
   localparam int alignLen = 32;
   localparam int maxDelay = 40;
   localparam int minGap   = 4;     // Clocks between decisionEn pulses
   localparam int idleLen  = 64;
   localparam int drainMax = 1000;

   logic            clk = 1'b0;
   logic            reset;
   logic            symEn;
   demodPkg::sample sampleI;
   demodPkg::sample sampleQ;
   logic            decision;
   logic            decisionEn;

   integer seed;
   int     encState    = 0;
   bit     txBits[$];              // Sent bits in time order
   bit     rxBits[$];              // Decoded bits in arrival order
   time    rxTimes[$];
   int     delay       = 0;
   bit     aligned     = 1'b0;
   int     nextCheck   = 0;
   int     cycle       = 0;
   int     lastPulse   = -100;
   int     pulseCount  = 0;
   int     errors      = 0;
   int     testErrors  = 0;
   int     testsRun    = 0;
   int     testsFailed = 0;
   bit     timedOut    = 1'b0;

   trellisDecoder u_trellisDecoder (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sampleI    (sampleI),
      .sampleQ    (sampleQ),
      .decision   (decision),
      .decisionEn (decisionEn)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   // Collect decoded bits and check pulse spacing
   always @(negedge clk) begin
      if (decisionEn) begin
         assert (cycle - lastPulse >= minGap) else begin
            $display("Two decisionEn pulses only %0d clocks apart at %0t",
                     cycle - lastPulse, $time);
            testErrors++;
         end
         rxBits.push_back(decision);
         rxTimes.push_back($time);
         pulseCount++;
         lastPulse = cycle;
      end
      cycle++;
   end

   // ----------------------------------------
   // Encoder model
   // ----------------------------------------
   // Point on a circle of amplitude 100 at 18 degrees per state
   function automatic int pointCoord(input int st, input bit quad);
      real phase;
      real val;
      phase = 3.14159265358979 * 18.0 * st / 180.0;
      val   = quad ? 100.0 * $sin(phase) : 100.0 * $cos(phase);
      return $rtoi(val >= 0.0 ? val + 0.5 : val - 0.5);
   endfunction

   task automatic sendSymbol(input bit b, input int noiseAmp);
      int nI;
      int nQ;
      nI = 0;
      nQ = 0;
      if (b) begin
         encState = (encState + trellisPkg::trellisStride) % trellisPkg::numStates;
      end else begin
         encState = (encState + trellisPkg::numStates - trellisPkg::trellisStride)
                    % trellisPkg::numStates;
      end
      if (noiseAmp > 0) begin
         nI = $random(seed) % (noiseAmp + 1);   // Uniform in -amp..amp
         nQ = $random(seed) % (noiseAmp + 1);
      end
      @(negedge clk);
      sampleI = demodPkg::sample'(pointCoord(encState, 1'b0) + nI);
      sampleQ = demodPkg::sample'(pointCoord(encState, 1'b1) + nQ);
      symEn   = 1'b1;
      @(negedge clk);
      symEn = 1'b0;
      repeat (4) @(negedge clk);   // 6 clocks per symbol
      txBits.push_back(b);
   endtask

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   task automatic drainOutputs();
      int idle;
      int waited;
      idle   = 0;
      waited = 0;
      while (idle < idleLen && waited < drainMax) begin
         @(negedge clk);
         idle = decisionEn ? 0 : idle + 1;
         waited++;
      end
      if (idle < idleLen) begin
         $display("Timeout: decisionEn kept pulsing for %0d clocks", drainMax);
         timedOut = 1'b1;
         testErrors++;
      end
   endtask

   task automatic findAlignment();
      bit match;
      int t;
      aligned = 1'b0;
      for (int d = 0; d <= maxDelay && !aligned; d++) begin
         match = 1'b1;
         for (int i = 0; i < alignLen; i++) begin
            t = skipOut + i - d;
            if (t < 0 || t >= txBits.size() || rxBits[skipOut + i] != txBits[t]) begin
               match = 1'b0;
            end
         end
         if (match) begin
            aligned = 1'b1;
            delay   = d;
         end
      end
      assert (aligned) else begin
         $display("No delay from 0 to %0d lines up %0d decoded bits with the sent bits",
                  maxDelay, alignLen);
         testErrors++;
      end
   endtask

   task automatic compareDecoded();
      int t;
      for (int j = nextCheck; j < rxBits.size(); j++) begin
         t = j - delay;
         if (aligned && j >= skipOut && t >= 0 && t < txBits.size()) begin
            assert (rxBits[j] == txBits[t]) else begin
               $display("[ERROR] %0t decision (bit %0d): expected %0b, got %0b",
                        rxTimes[j], j, txBits[t], rxBits[j]);
               testErrors++;
            end
         end
      end
      nextCheck = rxBits.size();
   endtask

   // Only whole blocks count and at most 2 may still be inside the DUT
   task automatic checkPulseCount();
      int full;
      full = (txBits.size() / trellisPkg::tbDepth) * trellisPkg::tbDepth;
      assert (pulseCount % trellisPkg::tbDepth == 0 && pulseCount <= full &&
              pulseCount >= full - 2 * trellisPkg::tbDepth) else begin
         $display("[ERROR] %0t decisionEn count: expected %0d to %0d, got %0d", $time,
                  full - 2 * trellisPkg::tbDepth, full, pulseCount);
         testErrors++;
      end
   endtask

   task automatic reportTest(input string name);
      testsRun++;
      errors += testErrors;
      if (testErrors == 0) begin
         $display("Test %s: ok", name);
      end else begin
         testsFailed++;
         $display("Test %s: %0d errors", name, testErrors);
      end
      testErrors = 0;
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic checkIdleOutputs();
      repeat (20) begin
         @(negedge clk);
         assert (decisionEn == 1'b0) else begin
            $display("[ERROR] %0t decisionEn: expected 0, got %0b", $time, decisionEn);
            testErrors++;
         end
         assert (decision == 1'b0) else begin
            $display("[ERROR] %0t decision: expected 0, got %0b", $time, decision);
            testErrors++;
         end
      end
      reportTest("idle after reset");
   endtask

   task automatic decodeRandomBits();
      for (int n = 0; n < 96; n++) begin
         sendSymbol(($random(seed) & 1) == 1, 0);
      end
      drainOutputs();
      assert (rxBits.size() >= skipOut + alignLen) else begin
         $display("Only %0d decoded bits arrived, too few to find the delay", rxBits.size());
         testErrors++;
      end
      if (rxBits.size() >= skipOut + alignLen) begin
         findAlignment();
      end
      compareDecoded();
      checkPulseCount();
      reportTest("noiseless random bits");
   endtask

   task automatic decodeLongRuns();
      repeat (40) sendSymbol(1'b0, 0);
      repeat (40) sendSymbol(1'b1, 0);
      drainOutputs();
      compareDecoded();
      checkPulseCount();
      reportTest("long zero and one runs");
   endtask

   task automatic decodeNoisyBits();
      for (int n = 0; n < 96; n++) begin
         sendSymbol(($random(seed) & 1) == 1, 10);
      end
      drainOutputs();
      compareDecoded();
      checkPulseCount();
      reportTest("random bits with noise");
   endtask

   initial begin
      reset   = 1'b1;
      symEn   = 1'b0;
      sampleI = '0;
      sampleQ = '0;
      seed    = 27;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      checkIdleOutputs();
      decodeRandomBits();
      if (!timedOut) begin
         decodeLongRuns();
      end
      if (!timedOut) begin
         decodeNoisyBits();
      end

      $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
      if (errors == 0 && testsFailed == 0 && !timedOut) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- trellisDecoder.f
trellisPkg.sv
demodPkg.sv
bitLifo.sv
branchMetric.sv
acsUnit.sv
traceBackTable.sv
trellisDecoder.sv
trellisDecoderTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module trellisDecoderTb \
		-f trellisDecoder.f --Mdir obj_dir
	./obj_dir/VtrellisDecoderTb | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
